// File: tb/imem.hex
// one 64-bit word per line, line n holds word index n (address bits above bit 2)
// upper 32 bits are the instruction at byte 4 of the word, lower 32 bits at byte 0
00C30093003C0013
01C30193013C0113
02C30293023C0213
03C30393033C0313
04C30493043C0413
05C30593053C0513
06C30693063C0613
07C30793073C0713
08C30893083C0813
09C30993093C0913
0AC30A930A3C0A13
0BC30B930B3C0B13
0CC30C930C3C0C13
0DC30D930D3C0D13
0EC30E930E3C0E13
0FC30F930F3C0F13
10C31093103C1013
11C31193113C1113
12C31293123C1213
13C31393133C1313
14C31493143C1413
15C31593153C1513
16C31693163C1613
17C31793173C1713
18C31893183C1813
19C31993193C1913
1AC31A931A3C1A13
1BC31B931B3C1B13
1CC31C931C3C1C13
1DC31D931D3C1D13
1EC31E931E3C1E13
1FC31F931F3C1F13
20C32093203C2013
21C32193213C2113
22C32293223C2213
23C32393233C2313
24C32493243C2413
25C32593253C2513
26C32693263C2613
27C32793273C2713
28C32893283C2813
29C32993293C2913
2AC32A932A3C2A13
2BC32B932B3C2B13
2CC32C932C3C2C13
2DC32D932D3C2D13
2EC32E932E3C2E13
2FC32F932F3C2F13
30C33093303C3013
31C33193313C3113
32C33293323C3213
33C33393333C3313
34C33493343C3413
35C33593353C3513
36C33693363C3613
37C33793373C3713
38C33893383C3813
39C33993393C3913
3AC33A933A3C3A13
3BC33B933B3C3B13
3CC33C933C3C3C13
3DC33D933D3C3D13
3EC33E933E3C3E13
3FC33F933F3C3F13

// File: project.f
rtl/if_pkg.sv
rtl/pc_gen.sv
rtl/axi_rd_master.sv
rtl/imem_slave.sv
rtl/inst_select.sv
rtl/if_stage.sv
tb/tb_if_stage.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 \
  --top-module tb_if_stage -f project.f -o sim_tb_if_stage || exit 1
out="$(./obj_dir/sim_tb_if_stage)"
echo "$out"
echo "$out" | grep -qx "Result: PASSED" && exit 0 || exit 1

// File: tb/tb_if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_if_stage
  import if_pkg::*;
();

  localparam int CLK_HALF   = 2;
  localparam int RST_CYCLES = 4;
  // a stale return followed by the refetch, plus slack
  localparam int DELIVER_ALLOW = 16;
  // redirect strobe and the widest random gap
  localparam int STEP_OVERHEAD = 5;
  localparam int MARGIN        = 4;

  // one stimulus row
  typedef struct packed {
    int              idle;
    int              stall;
    logic            redir;
    logic [XLEN-1:0] target;
  } step_t;

  logic            clk = 1'b0;
  logic            rst_n;
  logic            stall_i;
  logic            redirect_i;
  logic [XLEN-1:0] redirect_pc_i;
  logic [ILEN-1:0] inst_o;
  logic            inst_valid_o;
  logic [XLEN-1:0] inst_pc_o;

  // reference copy of the instruction image
  logic [DLEN-1:0] model_mem [IMEM_WORDS];
  step_t           steps [$];
  // pc the next delivered instruction must carry
  logic [XLEN-1:0] exp_pc = RESET_PC;
  logic [31:0]     lfsr = 32'ha985ff17;

  int err_cnt       = 0;
  int seq_err_cnt   = 0;
  int deliv_cnt     = 0;
  int stall_total   = 0;
  int cycle_cnt     = 0;
  int timeout_limit = 0;

  always #CLK_HALF clk = ~clk;

  if_stage uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .inst_o        (inst_o),
    .inst_valid_o  (inst_valid_o),
    .inst_pc_o     (inst_pc_o)
  );

  function automatic void add_step(input int idle, input int stall, input logic redir,
                                   input logic [XLEN-1:0] target);
    step_t s;
    s.idle   = idle;
    s.stall  = stall;
    s.redir  = redir;
    s.target = target;
    steps.push_back(s);
  endfunction

  function automatic void fill_steps();
    // plain sequential run from reset
    add_step(20, 0, 1'b0, '0);
    add_step(3, 10, 1'b0, '0);
    // jumps to lower and upper halves
    add_step(5, 0, 1'b1, 64'h0000_0000_0000_0040);
    add_step(7, 0, 1'b1, 64'h0000_0000_0000_0044);
    // stall first, then jump
    add_step(2, 6, 1'b1, 64'h0000_0000_0000_0080);
    // target past the memory depth, index 1
    add_step(4, 0, 1'b1, 64'h0000_0000_0000_0208);
    // last word of the image, next fetch wraps to index 0
    add_step(9, 0, 1'b1, 64'h0000_0000_1000_01fc);
    add_step(12, 3, 1'b0, '0);
    add_step(1, 0, 1'b1, 64'h0000_0000_0000_0010);
    // back to back jumps
    add_step(0, 0, 1'b1, 64'h0000_0000_0000_0030);
    add_step(6, 1, 1'b0, '0);
    add_step(15, 0, 1'b0, '0);
  endfunction

  // word index is the address divided by 8, modulo the depth
  function automatic logic [ILEN-1:0] expected_inst(input logic [XLEN-1:0] pc);
    logic [IMEM_IDX_W-1:0] idx;
    logic [DLEN-1:0]       word;
    idx  = IMEM_IDX_W'((pc >> 3) % XLEN'(IMEM_WORDS));
    word = model_mem[idx];
    if (pc[2]) begin
      return word[63:32];
    end
    return word[31:0];
  endfunction

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // 0..3 extra idle cycles, one lfsr step per bit
  task automatic rand_gap(output int gap);
    int i;
    gap = 0;
    for (i = 0; i < 2; i++) begin
      gap  = (gap << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic apply_step(input step_t s);
    int gap;
    int start;
    int stall_base;
    rand_gap(gap);
    repeat (s.idle + gap) @(posedge clk);
    if (s.stall > 0) begin
      @(posedge clk);
      stall_i    <= 1'b1;
      stall_base = stall_total;
      repeat (s.stall) @(posedge clk);
      stall_i <= 1'b0;
      // only the fetch already in flight may come out
      assert (stall_total - stall_base <= 1) else begin
        seq_err_cnt++;
        $display("more than one instruction delivered during a %0d cycle stall", s.stall);
      end
    end
    if (s.redir) begin
      @(posedge clk);
      redirect_i    <= 1'b1;
      redirect_pc_i <= s.target;
      @(posedge clk);
      redirect_i <= 1'b0;
    end
    // each row ends on the next delivery
    start = deliv_cnt;
    wait (deliv_cnt != start);
  endtask

  // outputs checked mid-cycle, away from the driving edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (inst_valid_o) begin
        deliv_cnt++;
        if (stall_i) begin
          stall_total++;
        end
        assert (inst_pc_o == exp_pc) else begin
          err_cnt++;
          $display("Error: inst_pc_o 0x%h, expected 0x%h", inst_pc_o, exp_pc);
        end
        assert (inst_o == expected_inst(exp_pc)) else begin
          err_cnt++;
          $display("Error: inst_o 0x%h, expected 0x%h", inst_o, expected_inst(exp_pc));
        end
        exp_pc = exp_pc + XLEN'(4);
      end else begin
        assert (inst_o == NOP_INST) else begin
          err_cnt++;
          $display("Error: inst_o 0x%h, expected 0x%h", inst_o, NOP_INST);
        end
      end
      // redirect overrides the sequential successor
      if (redirect_i) begin
        exp_pc = redirect_pc_i;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    int total;
    rst_n         = 1'b0;
    stall_i       = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    $readmemh(IMEM_FILE, model_mem);
    fill_steps();
    total = RST_CYCLES;
    foreach (steps[i]) begin
      total += steps[i].idle + steps[i].stall + STEP_OVERHEAD + DELIVER_ALLOW;
    end
    timeout_limit = total * MARGIN;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    foreach (steps[i]) begin
      apply_step(steps[i]);
    end
    repeat (4) @(posedge clk);
    $display("deliveries %0d, value errors %0d, sequence errors %0d",
             deliv_cnt, err_cnt, seq_err_cnt);
    if (err_cnt == 0 && seq_err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module if_stage
  import if_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  // hold new fetches, in-flight one still completes
  input  wire logic            stall_i,
  input  wire logic            redirect_i,
  input  wire logic [XLEN-1:0] redirect_pc_i,
  output logic      [ILEN-1:0] inst_o,
  output logic                 inst_valid_o,
  output logic      [XLEN-1:0] inst_pc_o
);

  logic [XLEN-1:0] curr_pc;
  logic            fetch_req;
  logic            ar_valid;
  logic            ar_ready;
  logic [XLEN-1:0] ar_addr;
  logic            r_valid;
  logic            r_ready;
  logic [DLEN-1:0] r_data;
  logic [1:0]      r_resp;
  logic            r_last;
  logic            fetch_done;
  logic [DLEN-1:0] rdata;
  logic [XLEN-1:0] raddr;

  // request while not stalled, and not in a cycle where the pc is about to move,
  // so every issued address is the one pc_gen will settle on
  assign fetch_req = !(stall_i || redirect_i || inst_valid_o);

  // pc moves on delivered instructions only, stale returns leave it alone
  pc_gen u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_done_i  (inst_valid_o),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .curr_pc_o     (curr_pc)
  );

  axi_rd_master u_axi_rd_master (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (fetch_req),
    .req_addr_i   (curr_pc),
    .ar_valid_o   (ar_valid),
    .ar_ready_i   (ar_ready),
    .ar_addr_o    (ar_addr),
    .r_valid_i    (r_valid),
    .r_ready_o    (r_ready),
    .r_data_i     (r_data),
    .r_resp_i     (r_resp),
    .r_last_i     (r_last),
    .fetch_done_o (fetch_done),
    .rdata_o      (rdata),
    .raddr_o      (raddr)
  );

  imem_slave u_imem_slave (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .ar_addr_i  (ar_addr),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .r_data_o   (r_data),
    .r_resp_o   (r_resp),
    .r_last_o   (r_last)
  );

  // ar_valid high means a fetch has left the stage
  inst_select u_inst_select (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_done_i (fetch_done),
    .rdata_i      (rdata),
    .raddr_i      (raddr),
    .redirect_i   (redirect_i),
    .ar_issue_i   (ar_valid),
    .inst_o       (inst_o),
    .inst_valid_o (inst_valid_o),
    .inst_pc_o    (inst_pc_o)
  );

endmodule

`default_nettype wire

// File: rtl/inst_select.sv
`timescale 1ns/1ps
`default_nettype none

module inst_select
  import if_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  // completion from the read master
  input  wire logic            fetch_done_i,
  input  wire logic [DLEN-1:0] rdata_i,
  input  wire logic [XLEN-1:0] raddr_i,
  // redirect strobe from the later stage
  input  wire logic            redirect_i,
  // AR in flight, marks the start of an outstanding fetch
  input  wire logic            ar_issue_i,
  output logic      [ILEN-1:0] inst_o,
  output logic                 inst_valid_o,
  output logic      [XLEN-1:0] inst_pc_o
);

  logic            busy_q;
  logic            stale_q;
  logic            outstanding;
  logic            drop;
  logic            deliver;
  logic [ILEN-1:0] half;

  assign outstanding = busy_q || ar_issue_i;
  // stale from an earlier redirect, or redirected in this very cycle
  assign drop        = fetch_done_i && (stale_q || redirect_i);
  assign deliver     = fetch_done_i && !drop;
  // bit 2 picks the upper instruction of the 64-bit word
  assign half        = raddr_i[2] ? rdata_i[DLEN-1 -: ILEN] : rdata_i[ILEN-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      stale_q <= 1'b0;
    end else if (fetch_done_i) begin
      busy_q  <= 1'b0;
      stale_q <= 1'b0;
    end else begin
      if (ar_issue_i) begin
        busy_q <= 1'b1;
      end
      if (redirect_i && outstanding) begin
        stale_q <= 1'b1;
      end
    end
  end

  // nop whenever nothing valid is shown
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inst_valid_o <= 1'b0;
      inst_o       <= NOP_INST;
    end else begin
      inst_valid_o <= deliver;
      inst_o       <= deliver ? half : NOP_INST;
    end
  end

  always_ff @(posedge clk) begin
    if (deliver) begin
      inst_pc_o <= raddr_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/imem_slave.sv
`timescale 1ns/1ps
`default_nettype none

module imem_slave
  import if_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  // read address channel
  input  wire logic            ar_valid_i,
  output logic                 ar_ready_o,
  input  wire logic [XLEN-1:0] ar_addr_i,
  // read data channel
  output logic                 r_valid_o,
  input  wire logic            r_ready_i,
  output logic      [DLEN-1:0] r_data_o,
  output logic      [1:0]      r_resp_o,
  output logic                 r_last_o
);

  logic [DLEN-1:0]       mem [IMEM_WORDS];
  logic                  busy_q;
  logic                  r_valid_q;
  logic [IMEM_LAT_W-1:0] lat_cnt_q;
  logic [IMEM_IDX_W-1:0] idx_q;
  logic [DLEN-1:0]       r_data_q;
  logic                  ar_hs;
  logic                  load_data;

  initial begin
    $readmemh(IMEM_FILE, mem);
  end

  // accept a new address only while idle
  assign ar_ready_o = !busy_q;
  assign ar_hs      = ar_valid_i && ar_ready_o;
  // last wait cycle, data goes valid on the next edge
  assign load_data  = busy_q && !r_valid_q && (lat_cnt_q == IMEM_LAT_W'(1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      r_valid_q <= 1'b0;
      lat_cnt_q <= '0;
    end else if (ar_hs) begin
      busy_q    <= 1'b1;
      lat_cnt_q <= IMEM_LAT_W'(IMEM_LAT - 1);
    end else if (r_valid_q) begin
      // hold the beat until the master takes it
      if (r_ready_i) begin
        r_valid_q <= 1'b0;
        busy_q    <= 1'b0;
      end
    end else if (load_data) begin
      r_valid_q <= 1'b1;
    end else if (busy_q) begin
      lat_cnt_q <= lat_cnt_q - IMEM_LAT_W'(1);
    end
  end

  // word index from bits above the byte-in-word offset, wraps with the depth
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      idx_q <= ar_addr_i[3 +: IMEM_IDX_W];
    end
    if (load_data) begin
      r_data_q <= mem[idx_q];
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;
  // no error path in the model
  assign r_resp_o  = AXI_RESP_OKAY;
  assign r_last_o  = 1'b1;

  // R beat stays up and steady until the master accepts it
  a_r_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o)
  ) else $error("imem_slave: r_valid dropped or data changed before ready");

endmodule

`default_nettype wire

// File: rtl/axi_rd_master.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rd_master
  import if_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  // fetch request from the stage
  input  wire logic            req_i,
  input  wire logic [XLEN-1:0] req_addr_i,
  // read address channel
  output logic                 ar_valid_o,
  input  wire logic            ar_ready_i,
  output logic      [XLEN-1:0] ar_addr_o,
  // read data channel
  input  wire logic            r_valid_i,
  output logic                 r_ready_o,
  input  wire logic [DLEN-1:0] r_data_i,
  input  wire logic [1:0]      r_resp_i,
  input  wire logic            r_last_i,
  // completion towards the selector
  output logic                 fetch_done_o,
  output logic      [DLEN-1:0] rdata_o,
  output logic      [XLEN-1:0] raddr_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } state_t;

  state_t          state_q;
  logic [XLEN-1:0] addr_q;
  logic [DLEN-1:0] rdata_q;
  logic            issue;
  logic            ar_hs;
  logic            r_hs;

  // new request only when nothing is outstanding
  assign issue = (state_q == ST_IDLE) && req_i;
  assign ar_hs = ar_valid_o && ar_ready_i;
  assign r_hs  = r_valid_i && r_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (issue) begin
            state_q <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (ar_hs) begin
            state_q <= ST_DATA;
          end
        end
        ST_DATA: begin
          // single beat, back to idle on the R handshake
          if (r_hs) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // request address frozen at issue, read word kept after the beat
  always_ff @(posedge clk) begin
    if (issue) begin
      addr_q <= req_addr_i;
    end
    if (r_hs) begin
      rdata_q <= r_data_i;
    end
  end

  assign ar_valid_o = (state_q == ST_ADDR);
  assign ar_addr_o  = addr_q;
  assign r_ready_o  = (state_q == ST_DATA);

  // completion strobe in the handshake cycle itself
  assign fetch_done_o = r_hs;
  // live word on the beat, held copy afterwards
  assign rdata_o      = r_hs ? r_data_i : rdata_q;
  assign raddr_o      = addr_q;

  // AR must not drop or change before the slave takes it
  a_ar_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o)
  ) else $error("axi_rd_master: AR withdrawn or changed before ready");

  // single-beat fetch, every response OKAY and last
  a_r_okay_last : assert property (
    @(posedge clk) disable iff (!rst_n)
    r_hs |-> (r_resp_i == AXI_RESP_OKAY) && r_last_i
  ) else $error("axi_rd_master: bad response %b last %b", r_resp_i, r_last_i);

endmodule

`default_nettype wire

// File: rtl/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pc_gen
  import if_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst_n,
  // one pulse per instruction actually handed on
  input  wire logic            fetch_done_i,
  // later stage redirect, one-cycle strobe
  input  wire logic            redirect_i,
  input  wire logic [XLEN-1:0] redirect_pc_i,
  // address of the next fetch to issue
  output logic      [XLEN-1:0] curr_pc_o
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_seq;

  // sequential successor, 4-byte instructions only
  assign pc_seq = pc_q + XLEN'(4);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (redirect_i) begin
      // redirect beats a same-cycle advance
      pc_q <= redirect_pc_i;
    end else if (fetch_done_i) begin
      pc_q <= pc_seq;
    end
  end

  assign curr_pc_o = pc_q;

  // targets from the later stage must keep the fetch word-aligned
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (!rst_n)
    curr_pc_o[1:0] == 2'b00
  ) else $error("pc_gen: fetch pc %h not 4-byte aligned", curr_pc_o);

endmodule

`default_nettype wire

// File: rtl/if_pkg.sv
`default_nettype none

package if_pkg;

  // machine widths
  localparam int XLEN = 64;
  localparam int ILEN = 32;
  localparam int DLEN = 64;

  // addi x0, x0, 0
  localparam logic [ILEN-1:0] NOP_INST = 32'h0000_0013;

  // first fetch address out of reset
  localparam logic [XLEN-1:0] RESET_PC = '0;

  // instruction memory model, 64-bit words
  localparam int IMEM_WORDS = 64;
  localparam int IMEM_IDX_W = $clog2(IMEM_WORDS);

  // cycles from AR handshake to r_valid, must be 2 or more
  localparam int IMEM_LAT = 2;
  localparam int IMEM_LAT_W = $clog2(IMEM_LAT + 1);

  // read response codes
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // hex image for the memory model
  localparam string IMEM_FILE = "tb/imem.hex";

endpackage

`default_nettype wire
